// ==== loadStoreCpu.f ====
src/cpuPkg.sv
src/instructionDecoder.sv
src/controlSequencer.sv
src/registerDatapath.sv
src/loadStoreCpu.sv
tb/loadStoreCpu_checker.sv
tb/loadStoreCpuTb.sv

// ==== Bender.yml ====
package:
  name: loadStoreCpu

sources:
  - src/cpuPkg.sv
  - src/instructionDecoder.sv
  - src/controlSequencer.sv
  - src/registerDatapath.sv
  - src/loadStoreCpu.sv
  - target: test
    files:
      - tb/loadStoreCpu_checker.sv
      - tb/loadStoreCpuTb.sv

// ==== tb/loadStoreCpuTb.sv ====
`timescale 1ns/100ps

module loadStoreCpuTb;
    import cpuPkg::*;

    localparam int         AddrWidth    = 8;
    localparam int         StartAddress = 8'h10;
    localparam int         CycleLimit   = 400;    // All programs need about 200 cycles
    localparam logic [5:0] NoOp         = 6'h3A;  // Outside the executed opcodes

    logic        Clock;
    logic        Reset;
    byte_t       memReadData;
    memRequest_t memRequest;
    logic        instrDone;

    byte_t mem [256];
    int    progPtr;
    int    errorCount;
    int    cycleCount = 0;

    loadStoreCpu #(
        .AddrWidth    (AddrWidth),
        .StartAddress (StartAddress)
    ) u_loadStoreCpu (
        .Clock       (Clock),
        .Reset       (Reset),
        .memReadData (memReadData),
        .memRequest  (memRequest),
        .instrDone   (instrDone)
    );

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    // ============================================================
    // Memory model and run limit
    // ============================================================
    assign memReadData = memRequest.enable ? mem[memRequest.address[7:0]] : 8'h00;

    always @(posedge Clock) begin
        if (memRequest.enable && memRequest.write) begin
            mem[memRequest.address[7:0]] <= memRequest.writeData;
        end
    end

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
            $display("=== FAIL ===");
            $fatal(1, "Run stopped by timeout");
        end
    end

    // ============================================================
    // Helpers
    // ============================================================
    task automatic failWith(input string msg);
        errorCount++;
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (expected === actual) else begin
            failWith($sformatf("Mismatch %s: expected %h, actual %h",
                               testName, expected, actual));
        end
    endtask

    task automatic clearMemory();
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'h00;  // Opcode 0 retires as a no-op
        end
    endtask

    task automatic beginTest();
        @(negedge Clock);
        Reset = 1'b1;
        clearMemory();
        progPtr = StartAddress;
    endtask

    task automatic releaseReset();
        repeat (4) @(negedge Clock);
        Reset = 1'b0;  // First cycle out of reset is T0
    endtask

    task automatic putInstr(input logic [5:0] opcode, input regSel_t regSel,
                            input byte_t address);
        mem[progPtr]     = address;           // Low byte fetched first
        mem[progPtr + 1] = {opcode, regSel};
        progPtr += 2;
    endtask

    // Most significant byte goes to the lowest address
    task automatic putWord(input int address, input word_t value);
        for (int i = 0; i < 4; i++) begin
            mem[address + i] = value[31 - 8*i -: 8];
        end
    endtask

    function automatic word_t readWord(input int address);
        return {mem[address], mem[address + 1], mem[address + 2], mem[address + 3]};
    endfunction

    task automatic waitForDone(output int cycles);
        cycles = 0;
        do begin
            @(negedge Clock);
            cycles++;
        end while (!instrDone);
    endtask

    // ============================================================
    // Tests
    // ============================================================
    task automatic resetAndFetch();
        beginTest();
        putInstr(NoOp, 2'd0, 8'h00);
        releaseReset();
        checkValue("resetAndFetch enable", 1, memRequest.enable);
        checkValue("resetAndFetch write", 0, memRequest.write);
        checkValue("resetAndFetch address", StartAddress, memRequest.address);
        @(negedge Clock);
        checkValue("resetAndFetch second address", StartAddress + 1, memRequest.address);
    endtask

    task automatic loadLowThenStore();
        byte_t a;
        byte_t b;
        int    cycles;
        a = byte_t'($urandom);
        b = byte_t'($urandom);
        beginTest();
        mem[8'h80] = a;
        mem[8'h81] = b;
        putWord(8'h88, 32'hFFFF_FFFF);  // DR holds all ones when LDAL starts
        putInstr(LDAH, 2'd0, 8'h88);
        putInstr(LDAL, 2'd1, 8'h80);
        putInstr(STA, 2'd1, 8'h90);
        releaseReset();
        repeat (3) waitForDone(cycles);
        @(negedge Clock);  // Last store byte lands on this edge
        checkValue("loadLowThenStore", {16'h0000, a, b}, readWord(8'h90));
    endtask

    task automatic loadHighRoundTrip();
        word_t value;
        int    cycles;
        value = $urandom;
        beginTest();
        putWord(8'h84, value);
        putInstr(LDAH, 2'd2, 8'h84);
        putInstr(STA, 2'd2, 8'hA0);
        releaseReset();
        repeat (2) waitForDone(cycles);
        @(negedge Clock);
        checkValue("loadHighRoundTrip", value, readWord(8'hA0));
    endtask

    task automatic registerIndependence();
        word_t values [4];
        int    cycles;
        beginTest();
        for (int i = 0; i < 4; i++) begin
            values[i] = {4'(i), 28'($urandom)};  // Top nibble keeps them distinct
            putWord(8'hC0 + 4*i, values[i]);
            putInstr(LDAH, regSel_t'(i), byte_t'(8'hC0 + 4*i));
        end
        for (int i = 0; i < 4; i++) begin
            putInstr(STA, regSel_t'(i), byte_t'(8'hE0 + 4*i));
        end
        releaseReset();
        repeat (8) waitForDone(cycles);
        @(negedge Clock);
        for (int i = 0; i < 4; i++) begin
            checkValue($sformatf("registerIndependence R%0d", i), values[i],
                       readWord(8'hE0 + 4*i));
        end
    endtask

    task automatic noOpSkipped();
        word_t value;
        int    cycles;
        value = $urandom;
        beginTest();
        putWord(8'hB0, value);
        putWord(8'h50, 32'hEEEE_EEEE);  // Target if the no-op acted as a store
        putInstr(LDAH, 2'd3, 8'hB0);
        putInstr(NoOp, 2'd3, 8'h50);
        putInstr(STA, 2'd3, 8'hB8);
        releaseReset();
        waitForDone(cycles);
        do begin
            @(negedge Clock);
            assert (!memRequest.write) else failWith("noOpSkipped: memory write during no-op");
        end while (!instrDone);
        @(negedge Clock);
        checkValue("noOpSkipped fetch address", StartAddress + 4, memRequest.address);
        waitForDone(cycles);
        @(negedge Clock);
        checkValue("noOpSkipped stored word", value, readWord(8'hB8));
        checkValue("noOpSkipped untouched word", 32'hEEEE_EEEE, readWord(8'h50));
    endtask

    task automatic instructionLengths();
        int expected [5] = '{4, 7, 8, 9, 4};  // No-op, LDAL, STA, LDAH, no-op
        int cycles;
        beginTest();
        putInstr(NoOp, 2'd0, 8'h00);
        putInstr(NoOp, 2'd1, 8'h00);
        putInstr(LDAL, 2'd0, 8'h60);
        putInstr(STA, 2'd0, 8'h70);
        putInstr(LDAH, 2'd1, 8'h60);
        putInstr(NoOp, 2'd2, 8'h00);
        releaseReset();
        waitForDone(cycles);  // No earlier pulse to measure from
        foreach (expected[i]) begin
            waitForDone(cycles);
            checkValue($sformatf("instructionLengths pair %0d", i), expected[i], cycles);
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        Reset      = 1'b1;
        errorCount = 0;
        progPtr    = StartAddress;
        clearMemory();
        void'($urandom(32'h2d694234));
        resetAndFetch();
        loadLowThenStore();
        loadHighRoundTrip();
        registerIndependence();
        noOpSkipped();
        instructionLengths();
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== tb/loadStoreCpu_checker.sv ====
`timescale 1ns/100ps

module loadStoreCpu_checker (
    input logic                Clock,
    input logic                Reset,
    input cpuPkg::memRequest_t memRequest,
    input logic                instrDone
);

    // A write strobe only counts with the memory selected
    writeNeedsEnable: assert property (
        @(posedge Clock) disable iff (Reset)
        memRequest.write |-> memRequest.enable
    ) else $error("memWrite high without memEnable");

    donePulse: assert property (
        @(posedge Clock) disable iff (Reset)
        instrDone |=> !instrDone
    ) else $error("instrDone high for two cycles in a row");

    // Covers the reset cycles and the first T0 after release
    quietOutOfReset: assert property (
        @(posedge Clock)
        (Reset || $fell(Reset)) |-> (!memRequest.write && !instrDone)
    ) else $error("memWrite or instrDone high in or right after reset");

endmodule

bind loadStoreCpu loadStoreCpu_checker u_loadStoreCpu_checker (
    .Clock      (Clock),
    .Reset      (Reset),
    .memRequest (memRequest),
    .instrDone  (instrDone)
);

// ==== src/loadStoreCpu.sv ====
`timescale 1ns/100ps

module loadStoreCpu #(
    parameter int AddrWidth    = 8,  // At most cpuPkg::MaxAddrWidth
    parameter int StartAddress = 0   // First fetch address after reset
) (
    input  logic                Clock,
    input  logic                Reset,
    input  cpuPkg::byte_t       memReadData,
    output cpuPkg::memRequest_t memRequest,
    output logic                instrDone
);
    import cpuPkg::*;

    ctrlWord_t    ctrl;    // From sequencer to decoder and datapath
    instrFields_t fields;  // Latched instruction fields

    // ============================================================
    // Fetch and decode
    // ============================================================
    instructionDecoder u_instructionDecoder (
        .Clock       (Clock),
        .Reset       (Reset),
        .ctrl        (ctrl),
        .memReadData (memReadData),
        .fields      (fields)
    );

    // ============================================================
    // Timing states
    // ============================================================
    controlSequencer u_controlSequencer (
        .Clock     (Clock),
        .Reset     (Reset),
        .fields    (fields),
        .ctrl      (ctrl),
        .instrDone (instrDone)
    );

    // ============================================================
    // Registers and memory port
    // ============================================================
    registerDatapath #(
        .AddrWidth    (AddrWidth),
        .StartAddress (StartAddress)
    ) u_registerDatapath (
        .Clock       (Clock),
        .Reset       (Reset),
        .ctrl        (ctrl),
        .fields      (fields),
        .memReadData (memReadData),
        .memRequest  (memRequest)
    );

endmodule

// ==== src/registerDatapath.sv ====
`timescale 1ns/100ps

module registerDatapath #(
    parameter int AddrWidth    = 8,
    parameter int StartAddress = 0
) (
    input  logic                 Clock,
    input  logic                 Reset,
    input  cpuPkg::ctrlWord_t    ctrl,
    input  cpuPkg::instrFields_t fields,
    input  cpuPkg::byte_t        memReadData,
    output cpuPkg::memRequest_t  memRequest
);
    import cpuPkg::*;

    logic [AddrWidth-1:0] pc;
    logic [AddrWidth-1:0] ar;
    logic [AddrWidth-1:0] memAddr;
    word_t                dr;
    word_t                drBase;
    word_t                regFile [4];  // R0..R3
    logic                 fetching;

    byte_t [BytesPerWord-1:0] storeBytes;  // Rx viewed byte by byte

    // ============================================================
    // Program counter and address register
    // ============================================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc <= AddrWidth'(StartAddress);
        end else if (ctrl.pcIncrement) begin
            pc <= pc + 1'b1;  // Wraps at 2**AddrWidth
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            ar <= '0;
        end else if (ctrl.arLoad) begin
            ar <= AddrWidth'(fields.address);  // Zero-extended
        end else if (ctrl.arIncrement) begin
            ar <= ar + 1'b1;
        end
    end

    // ============================================================
    // Data register
    // ============================================================
    // Loads come in most significant byte first, so each byte enters
    // at the bottom and older bytes move up
    assign drBase = ctrl.drClear ? '0 : dr;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            dr <= '0;
        end else if (ctrl.drShiftIn) begin
            dr <= {drBase[23:0], memReadData};
        end
    end

    // ============================================================
    // Register file
    // ============================================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < 4; i++) begin
                regFile[i] <= '0;
            end
        end else if (ctrl.regWrite) begin
            regFile[fields.regSel] <= dr;  // Write back load result
        end
    end

    assign storeBytes = regFile[fields.regSel];

    // ============================================================
    // Memory request
    // ============================================================
    assign fetching = ctrl.irLoadLow || ctrl.irLoadHigh;
    assign memAddr  = fetching ? pc : ar;  // Instruction or data address

    always_comb begin
        memRequest.enable    = ctrl.memEnable;
        memRequest.write     = ctrl.memWrite;
        memRequest.address   = MaxAddrWidth'(memAddr);
        memRequest.writeData = storeBytes[ctrl.storeByteSel];
    end

endmodule

// ==== src/controlSequencer.sv ====
`timescale 1ns/100ps

module controlSequencer (
    input  logic                 Clock,
    input  logic                 Reset,
    input  cpuPkg::instrFields_t fields,
    output cpuPkg::ctrlWord_t    ctrl,
    output logic                 instrDone
);
    import cpuPkg::*;

    cpuState_e state;
    cpuState_e nextState;
    cpuState_e lastState;  // End state of the current opcode
    logic      isLoad;
    logic      isStore;

    // ============================================================
    // Opcode classification
    // ============================================================
    always_comb begin
        unique case (fields.opcode)
            LDAL:    lastState = T6;  // Two reads then write back
            LDAH:    lastState = T8;  // Four reads then write back
            STA:     lastState = T7;  // Four writes
            default: lastState = T3;  // Retire right after decode
        endcase
    end

    assign isLoad  = (fields.opcode == LDAL) || (fields.opcode == LDAH);
    assign isStore = (fields.opcode == STA);

    // Fields are stale during T0..T2 but lastState is never below T3,
    // so no early match is possible there
    assign instrDone = (state == lastState);

    // ============================================================
    // State register
    // ============================================================
    always_comb begin
        if (instrDone) begin
            nextState = T0;
        end else begin
            nextState = cpuState_e'(state + 1);  // One state per cycle
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            state <= T0;
        end else begin
            state <= nextState;
        end
    end

    // ============================================================
    // Control word
    // ============================================================
    always_comb begin
        ctrl = '0;
        unique case (state)
            T0: begin
                ctrl.memEnable   = 1'b1;
                ctrl.irLoadLow   = 1'b1;  // Low byte at PC
                ctrl.pcIncrement = 1'b1;
            end
            T1: begin
                ctrl.memEnable  = 1'b1;
                ctrl.irLoadHigh = 1'b1;   // High byte at PC+1
            end
            T2: begin
                ctrl.decodeLatch = 1'b1;
                ctrl.pcIncrement = 1'b1;  // PC now at next instruction
            end
            T3: begin
                ctrl.arLoad = isLoad || isStore;  // AR from address byte
            end
            default: begin
                if (isLoad) begin
                    if (state == lastState) begin
                        ctrl.regWrite = 1'b1;  // Rx <- DR
                    end else begin
                        ctrl.memEnable   = 1'b1;
                        ctrl.drClear     = (state == T4);  // Zero-fill upper bytes
                        ctrl.drShiftIn   = 1'b1;
                        ctrl.arIncrement = 1'b1;
                    end
                end else if (isStore) begin
                    ctrl.memEnable    = 1'b1;
                    ctrl.memWrite     = 1'b1;
                    // Byte 3 goes to the lowest address at T4 in big-endian order
                    ctrl.storeByteSel = 2'(T7 - state);
                    ctrl.arIncrement  = (state != lastState);
                end
            end
        endcase
    end

endmodule

// ==== src/instructionDecoder.sv ====
`timescale 1ns/100ps

module instructionDecoder (
    input  logic                 Clock,
    input  logic                 Reset,
    input  cpuPkg::ctrlWord_t    ctrl,
    input  cpuPkg::byte_t        memReadData,
    output cpuPkg::instrFields_t fields
);
    import cpuPkg::*;

    // ============================================================
    // Instruction register
    // ============================================================
    logic [15:0] instrReg;  // Assembled over two fetch cycles

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            instrReg <= '0;
        end else begin
            if (ctrl.irLoadLow) begin
                instrReg[7:0] <= memReadData;   // First byte at PC
            end
            if (ctrl.irLoadHigh) begin
                instrReg[15:8] <= memReadData;  // Second byte at PC+1
            end
        end
    end

    // ============================================================
    // Decoded fields
    // ============================================================
    // Held for the whole execute phase so the IR may be refilled freely.
    // Codes outside LDAL/LDAH/STA go through as they are; the sequencer
    // retires them at T3.
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            fields <= '0;
        end else if (ctrl.decodeLatch) begin
            fields <= instrFields_t'(instrReg);  // Split opcode, Rx and address
        end
    end

endmodule

// ==== src/cpuPkg.sv ====
package cpuPkg;

    // ============================================================
    // Basic widths and constants
    // ============================================================
    localparam int MaxAddrWidth = 16;  // Widest supported memory address
    localparam int BytesPerWord = 4;   // Bytes in one register word

    typedef logic [1:0]  regSel_t;     // R0..R3 index
    typedef logic [7:0]  byte_t;       // One memory byte
    typedef logic [31:0] word_t;       // One register word

    // ============================================================
    // Opcodes
    // ============================================================
    // Full legacy code space is kept so that old programs still decode.
    // Only LDAL, LDAH and STA execute; everything else retires after decode.
    typedef enum logic [5:0] {
        BRA   = 6'h00,
        BNE   = 6'h01,
        BEQ   = 6'h02,
        POPL  = 6'h03,
        PSHL  = 6'h04,
        POPH  = 6'h05,
        PSHH  = 6'h06,
        CALL  = 6'h07,
        RET   = 6'h08,
        INC   = 6'h09,
        DEC   = 6'h0A,
        LSL   = 6'h0B,
        LSR   = 6'h0C,
        ASR   = 6'h0D,
        CSL   = 6'h0E,
        CSR   = 6'h0F,
        NOT   = 6'h10,
        AND   = 6'h11,
        ORR   = 6'h12,
        XOR   = 6'h13,
        NAND  = 6'h14,
        ADD   = 6'h15,
        ADC   = 6'h16,
        SUB   = 6'h17,
        MOV   = 6'h18,
        MOVL  = 6'h19,
        MOVSH = 6'h1A,
        LDARL = 6'h1B,
        LDARH = 6'h1C,
        STAR  = 6'h1D,
        LDAL  = 6'h1E,  // Load two bytes
        LDAH  = 6'h1F,  // Load four bytes
        STA   = 6'h20,  // Store four bytes
        LDDRL = 6'h21,
        LDDRH = 6'h22,
        STDR  = 6'h23,
        STRIM = 6'h24
    } opcode_e;

    // Timing states of the sequencer
    typedef enum logic [3:0] {
        T0, T1, T2, T3, T4, T5, T6, T7, T8
    } cpuState_e;

    // ============================================================
    // Structs
    // ============================================================
    typedef struct packed {
        opcode_e opcode;   // Bits 15:10
        regSel_t regSel;   // Bits 9:8
        byte_t   address;  // Bits 7:0
    } instrFields_t;

    typedef struct packed {
        logic       irLoadLow;
        logic       irLoadHigh;
        logic       decodeLatch;
        logic       pcIncrement;
        logic       arLoad;
        logic       arIncrement;
        logic       memEnable;
        logic       memWrite;
        logic       drClear;
        logic       drShiftIn;
        logic       regWrite;
        logic [1:0] storeByteSel;  // Byte of Rx on the write bus
    } ctrlWord_t;

    typedef struct packed {
        logic                    enable;
        logic                    write;
        logic [MaxAddrWidth-1:0] address;  // Upper bits zero for narrow memories
        byte_t                   writeData;
    } memRequest_t;

endpackage
